/* ice_spi_top.f */
logic/spi_cmd_pkg.sv
logic/spi_msg_rx.sv
logic/spi_cmd_exec.sv
logic/spi_resp_tx.sv
logic/ice_spi_top.sv
verif/tb_clock_gen.sv
verif/tb_ice_spi_checker.sv
verif/tb_ice_spi_top.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing -j 0
TOP         = tb_ice_spi_top
RTL_TOP     = ice_spi_top
FILELIST    = ice_spi_top.f
OBJ_DIR     = obj_dir
LOG         = sim.log
FAIL_MSG    = SIMULATION FAILED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# A crashed run counts as a failed one
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_ice_spi_top.sv */
`timescale 1ns/1ps

module tb_ice_spi_top;

    logic       ice_st_spi_clk;
    logic       reset_cs;
    logic       cs_drive;
    logic       spi_cs;
    logic [7:0] spi_d_in;
    logic [7:0] spi_d_out;
    logic       spi_d_out_en;
    logic [3:0] ice_led;
    logic       img_rst_n;

    int          value_errors;
    int          beats_checked;
    int          timeouts;
    int          resp_sends;
    logic [31:0] rng_state;

    // Host select is forced low while reset runs
    assign spi_cs = reset_cs & cs_drive;

    tb_clock_gen clock_gen_inst (
        .ice_st_spi_clk (ice_st_spi_clk),
        .reset_cs       (reset_cs)
    );

    ice_spi_top ice_spi_top_inst (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .spi_d_out      (spi_d_out),
        .spi_d_out_en   (spi_d_out_en),
        .ice_led        (ice_led),
        .img_rst_n      (img_rst_n)
    );

    tb_ice_spi_checker spi_checker_inst (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .spi_d_out      (spi_d_out),
        .spi_d_out_en   (spi_d_out_en),
        .ice_led        (ice_led),
        .img_rst_n      (img_rst_n),
        .value_errors   (value_errors),
        .beats_checked  (beats_checked)
    );

    // ==============================
    // Random source
    // ==============================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;

        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic random_arg(output logic [55:0] a);
        logic [31:0] r1;
        logic [31:0] r2;

        next_random(r1);
        next_random(r2);
        a = {r1[23:0], r2};
    endtask

    // ==============================
    // Host side
    // ==============================

    task automatic wait_reset_release();
        int n;

        n = 0;
        while (!reset_cs && n < 40) begin
            @(posedge ice_st_spi_clk);
            n++;
        end
        if (!reset_cs) begin
            timeouts++;
            $display("Timeout: the reset never released spi_cs");
        end
    endtask

    // One selection where cut_after below 19 drops spi_cs before the message completes
    task automatic send_message(input logic [7:0] msg_type, input logic [55:0] arg,
                                input int cut_after, input logic expect_resp);
        logic [63:0] word;
        logic [31:0] r;
        int          i;
        int          seen;
        int          n;

        word = {msg_type, arg};
        for (i = 0; i < 19 && i < cut_after; i++) begin
            @(negedge ice_st_spi_clk);
            next_random(r);
            // Start cycle and dummy byte are random filler
            if (i < 3) begin
                spi_d_in = r[7:0];
            end else begin
                spi_d_in = {r[7:4], word[63 - 4 * (i - 3) -: 4]};
            end
            if (i == 0) begin
                cs_drive = 1'b1;
            end
        end

        if (cut_after >= 19 && expect_resp) begin
            // Eight beats plus two trailing zero beats
            seen = 0;
            n = 0;
            while (seen < spi_cmd_pkg::resp_beat_count + 2 && n < 40) begin
                @(negedge ice_st_spi_clk);
                n++;
                if (spi_d_out_en) begin
                    seen++;
                end
            end
            if (seen < spi_cmd_pkg::resp_beat_count + 2) begin
                timeouts++;
                $display("Timeout: response for type 0x%h never completed", msg_type);
            end
        end else if (cut_after >= 19) begin
            repeat (6) @(negedge ice_st_spi_clk);
        end

        @(negedge ice_st_spi_clk);
        cs_drive = 1'b0;
        repeat (4) @(negedge ice_st_spi_clk);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        logic [55:0] arg;
        int          k;

        cs_drive = 1'b0;
        spi_d_in = 8'h00;
        timeouts = 0;
        resp_sends = 0;
        rng_state = 32'd196;

        wait_reset_release();
        repeat (2) @(negedge ice_st_spi_clk);

        random_arg(arg);
        send_message(8'h80, arg, 19, 1'b0);

        // Sensor reset level follows arg bit 0
        random_arg(arg);
        arg[0] = 1'b1;
        send_message(8'h82, arg, 19, 1'b0);
        arg[0] = 1'b0;
        send_message(8'h82, arg, 19, 1'b0);
        arg[0] = 1'b1;
        send_message(8'h82, arg, 19, 1'b0);

        for (k = 0; k < 4; k++) begin
            random_arg(arg);
            send_message(8'h81, arg, 19, 1'b0);
        end

        // LED value has to survive these
        random_arg(arg);
        send_message(8'h80, arg, 19, 1'b0);
        random_arg(arg);
        send_message(8'h80, arg, 19, 1'b0);

        for (k = 0; k < 6; k++) begin
            random_arg(arg);
            send_message(8'hC0, arg, 19, 1'b1);
            resp_sends++;
        end

        // Bit 7 cleared by the host still decodes as LED set and echo
        random_arg(arg);
        arg[3:0] = ~ice_led;
        send_message(8'h01, arg, 19, 1'b0);
        random_arg(arg);
        send_message(8'h40, arg, 19, 1'b1);
        resp_sends++;

        // Unknown codes with and without the response bit
        random_arg(arg);
        send_message(8'h85, arg, 19, 1'b0);
        random_arg(arg);
        send_message(8'hC3, arg, 19, 1'b0);

        // Aborted selections must leave the held levels alone
        random_arg(arg);
        arg[3:0] = ~ice_led;
        send_message(8'h81, arg, 10, 1'b0);
        random_arg(arg);
        arg[0] = ~img_rst_n;
        send_message(8'h82, arg, 18, 1'b0);

        random_arg(arg);
        send_message(8'h80, arg, 19, 1'b0);
        repeat (4) @(negedge ice_st_spi_clk);

        $display("Value mismatches: %0d, timeouts: %0d, beats checked: %0d of %0d",
                 value_errors, timeouts, beats_checked,
                 resp_sends * spi_cmd_pkg::resp_beat_count);
        if (value_errors == 0 && timeouts == 0 &&
            beats_checked == resp_sends * spi_cmd_pkg::resp_beat_count) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verif/tb_ice_spi_checker.sv */
`timescale 1ns/1ps

module tb_ice_spi_checker (
    input  logic       ice_st_spi_clk,
    input  logic       spi_cs,
    input  logic [7:0] spi_d_in,
    input  logic [7:0] spi_d_out,
    input  logic       spi_d_out_en,
    input  logic [3:0] ice_led,
    input  logic       img_rst_n,
    output int         value_errors,
    output int         beats_checked
);

    // Expected effect of one decoded message
    typedef struct packed {
        logic [3:0]  led;
        logic        rst_n;
        logic        has_resp;
        logic [63:0] resp;
    } expect_t;

    int          edge_cnt;
    logic [63:0] rx_word;
    expect_t     pending;

    // Held levels, power-up values first
    logic [3:0]  exp_led;
    logic        exp_rst_n;
    logic        resp_on;
    logic [63:0] resp_word;

    // ==============================
    // Reference model
    // ==============================

    function automatic expect_t predict(input logic [63:0] word, input logic [3:0] led_now,
                                        input logic rst_now);
        expect_t     e;
        logic [7:0]  op;
        logic [55:0] arg;

        // Top type bit always reads as one
        op = {1'b1, word[62:56]};
        arg = word[55:0];
        e.led = led_now;
        e.rst_n = rst_now;
        e.has_resp = 1'b0;
        e.resp = '0;
        case (op)
            8'h81: begin
                e.led = arg[3:0];
            end
            8'h82: begin
                e.rst_n = arg[0];
            end
            8'hC0: begin
                e.has_resp = 1'b1;
                e.resp = {arg, 8'h00};
            end
            default: begin
                // nop and unknown codes
            end
        endcase
        return e;
    endfunction

    // Beat idx of a response, words MSW first, nibbles interleaved
    function automatic logic [7:0] beat_of(input logic [63:0] word, input int idx);
        logic [15:0] w;

        w = word[(3 - idx / 2) * 16 +: 16];
        if (idx % 2 == 0) begin
            return {w[15:12], w[7:4]};
        end else begin
            return {w[11:8], w[3:0]};
        end
    endfunction

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            value_errors++;
            $display("Fail %s: got 0x%h expected 0x%h at %0t ns (edge %0d)",
                     name, got, want, $time, edge_cnt);
        end
    endtask

    initial begin
        value_errors = 0;
        beats_checked = 0;
        edge_cnt = 0;
        rx_word = '0;
        pending = '0;
        exp_led = 4'h0;
        exp_rst_n = 1'b0;
        resp_on = 1'b0;
        resp_word = '0;
    end

    // ==============================
    // Compare process
    // ==============================

    // Outputs seen here are the result of edge number edge_cnt
    always @(posedge ice_st_spi_clk) begin
        compare("ice_led", {4'h0, ice_led}, {4'h0, exp_led});
        compare("img_rst_n", {7'h00, img_rst_n}, {7'h00, exp_rst_n});
        if (!spi_cs) begin
            compare("spi_d_out_en", {7'h00, spi_d_out_en}, 8'h00);
            edge_cnt = 0;
            resp_on = 1'b0;
        end else begin
            // First beat follows edge 22
            compare("spi_d_out_en", {7'h00, spi_d_out_en},
                    {7'h00, resp_on && edge_cnt >= 22});
            if (resp_on && edge_cnt >= 22) begin
                if (edge_cnt < 22 + spi_cmd_pkg::resp_beat_count) begin
                    compare("spi_d_out", spi_d_out, beat_of(resp_word, edge_cnt - 22));
                    beats_checked++;
                end else begin
                    compare("spi_d_out", spi_d_out, 8'h00);
                end
            end

            edge_cnt++;
            // Message nibbles on edges 4 to 19
            if (edge_cnt >= 4 && edge_cnt <= 19) begin
                rx_word = {rx_word[59:0], spi_d_in[3:0]};
            end
            if (edge_cnt == 20) begin
                pending = predict(rx_word, exp_led, exp_rst_n);
            end
            if (edge_cnt == 21) begin
                exp_led = pending.led;
                exp_rst_n = pending.rst_n;
                resp_on = pending.has_resp;
                resp_word = pending.resp;
            end
        end
    end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic ice_st_spi_clk,
    output logic reset_cs
);

    // 10 ns period
    initial begin
        ice_st_spi_clk = 1'b0;
        forever begin
            #5 ice_st_spi_clk = ~ice_st_spi_clk;
        end
    end

    // Keeps spi_cs low for the first 16 cycles, released on a falling edge
    initial begin
        reset_cs = 1'b0;
        repeat (16) @(posedge ice_st_spi_clk);
        @(negedge ice_st_spi_clk);
        reset_cs = 1'b1;
    end

endmodule

/* logic/ice_spi_top.sv */
`timescale 1ns/1ps

module ice_spi_top (
    input  logic       ice_st_spi_clk,
    input  logic       spi_cs,
    input  logic [7:0] spi_d_in,
    output logic [7:0] spi_d_out,
    output logic       spi_d_out_en,
    output logic [3:0] ice_led,
    output logic       img_rst_n
);

    // ==============================
    // Internal nets
    // ==============================

    spi_cmd_pkg::spi_msg_t msg;
    logic msg_valid;

    logic [spi_cmd_pkg::resp_len-1:0] resp;
    logic resp_load;

    // ==============================
    // Command path
    // ==============================

    // Commands arrive on the low four lines only
    spi_msg_rx spi_msg_rx_inst (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in[3:0]),
        .msg            (msg),
        .msg_valid      (msg_valid)
    );

    spi_cmd_exec spi_cmd_exec_inst (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .msg            (msg),
        .msg_valid      (msg_valid),
        .ice_led        (ice_led),
        .img_rst_n      (img_rst_n),
        .resp           (resp),
        .resp_load      (resp_load)
    );

    // ==============================
    // Response path
    // ==============================

    // Pad direction is handled in the board wrapper from spi_d_out_en
    spi_resp_tx spi_resp_tx_inst (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .resp           (resp),
        .resp_load      (resp_load),
        .spi_d_out      (spi_d_out),
        .spi_d_out_en   (spi_d_out_en)
    );

endmodule

/* logic/spi_resp_tx.sv */
`timescale 1ns/1ps

module spi_resp_tx (
    input  logic        ice_st_spi_clk,
    input  logic        spi_cs,
    input  logic [63:0] resp,
    input  logic        resp_load,
    output logic [7:0]  spi_d_out,
    output logic        spi_d_out_en
);

    spi_cmd_pkg::tx_state_t state;

    // Response rearranged so that each byte is one beat
    logic [spi_cmd_pkg::resp_len-1:0] beats;

    logic [spi_cmd_pkg::resp_len-1:0] shreg;

    // ==============================
    // Beat ordering
    // ==============================

    // Per word the host expects bits 15..12 with 7..4, then 11..8 with 3..0
    always_comb begin
        logic [spi_cmd_pkg::resp_word_len-1:0] word;

        beats = '0;
        for (int w = 0; w < spi_cmd_pkg::resp_beat_count / 2; w++) begin
            word = resp[w*spi_cmd_pkg::resp_word_len +: spi_cmd_pkg::resp_word_len];
            beats[w*spi_cmd_pkg::resp_word_len +: spi_cmd_pkg::resp_word_len] =
                {word[15:12], word[7:4], word[11:8], word[3:0]};
        end
    end

    // ==============================
    // State
    // ==============================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            state <= spi_cmd_pkg::tx_idle;
        end else begin
            case (state)
                spi_cmd_pkg::tx_idle: begin
                    if (resp_load) begin
                        state <= spi_cmd_pkg::tx_send;
                    end
                end

                // Stays driving until deselect
                spi_cmd_pkg::tx_send: begin
                    state <= spi_cmd_pkg::tx_send;
                end

                default: begin
                    state <= spi_cmd_pkg::tx_idle;
                end
            endcase
        end
    end

    // ==============================
    // Output shifter
    // ==============================

    // Most significant word leaves first, zeros follow the last beat
    always_ff @(posedge ice_st_spi_clk) begin
        if (resp_load) begin
            shreg <= beats;
        end else begin
            shreg <= {shreg[spi_cmd_pkg::resp_len-2*spi_cmd_pkg::nibble_len-1:0],
                      {(2*spi_cmd_pkg::nibble_len){1'b0}}};
        end
    end

    assign spi_d_out = shreg[spi_cmd_pkg::resp_len-1 -: 2*spi_cmd_pkg::nibble_len];
    assign spi_d_out_en = (state == spi_cmd_pkg::tx_send);

endmodule

/* logic/spi_cmd_exec.sv */
`timescale 1ns/1ps

module spi_cmd_exec (
    input  logic                  ice_st_spi_clk,
    input  logic                  spi_cs,
    input  spi_cmd_pkg::spi_msg_t msg,
    input  logic                  msg_valid,
    output logic [3:0]            ice_led,
    output logic                  img_rst_n,
    output logic [63:0]           resp,
    output logic                  resp_load
);

    spi_cmd_pkg::spi_opcode_t opcode;

    logic known_op;
    logic want_resp;

    // Held across selections, power up with LEDs off and sensor in reset
    logic [spi_cmd_pkg::led_width-1:0] led_q = '0;
    logic img_rst_q = 1'b0;

    logic [spi_cmd_pkg::resp_len-1:0] resp_q;

    // ==============================
    // Decode
    // ==============================

    assign opcode = spi_cmd_pkg::spi_opcode_t'(msg.msg_type);
    assign want_resp = msg.msg_type[spi_cmd_pkg::msg_type_resp_bit];

    always_comb begin
        case (opcode)
            spi_cmd_pkg::op_nop,
            spi_cmd_pkg::op_led_set,
            spi_cmd_pkg::op_img_reset,
            spi_cmd_pkg::op_echo: begin
                known_op = 1'b1;
            end
            default: begin
                known_op = 1'b0;
            end
        endcase
    end

    // ==============================
    // Response strobe
    // ==============================

    // Unknown codes never start the transmitter, even with the response bit
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            resp_load <= 1'b0;
        end else begin
            resp_load <= msg_valid && want_resp && known_op;
        end
    end

    // ==============================
    // Held registers and response word
    // ==============================

    always_ff @(posedge ice_st_spi_clk) begin
        if (msg_valid) begin
            case (opcode)
                spi_cmd_pkg::op_led_set: begin
                    led_q <= msg.arg[spi_cmd_pkg::led_width-1:0];
                end

                spi_cmd_pkg::op_img_reset: begin
                    img_rst_q <= msg.arg[spi_cmd_pkg::img_rst_bit];
                end

                // Argument goes back in the upper bits, low byte zero
                spi_cmd_pkg::op_echo: begin
                    resp_q <= {msg.arg, {(spi_cmd_pkg::resp_len-spi_cmd_pkg::msg_arg_len){1'b0}}};
                end

                spi_cmd_pkg::op_nop: begin
                    // Nothing to do
                end

                default: begin
                    // Unknown codes behave like nop
                end
            endcase
        end
    end

    assign ice_led = led_q;
    assign img_rst_n = img_rst_q;
    assign resp = resp_q;

endmodule

/* logic/spi_msg_rx.sv */
`timescale 1ns/1ps

module spi_msg_rx (
    input  logic                  ice_st_spi_clk,
    input  logic                  spi_cs,
    input  logic [3:0]            spi_d_in,
    output spi_cmd_pkg::spi_msg_t msg,
    output logic                  msg_valid
);

    spi_cmd_pkg::rx_state_t state;

    // Edges left until the last message nibble
    logic [spi_cmd_pkg::rx_cnt_width-1:0] cycle_cnt;

    // Set on the edge that takes the last nibble
    logic msg_done;

    logic [spi_cmd_pkg::msg_len-1:0] shreg;

    // ==============================
    // Nibble shift register
    // ==============================

    // Samples every edge; the start and dummy nibbles fall off the top
    always_ff @(posedge ice_st_spi_clk) begin
        shreg <= {shreg[spi_cmd_pkg::msg_len-spi_cmd_pkg::nibble_len-1:0], spi_d_in};
    end

    // ==============================
    // Sequencing
    // ==============================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            state <= spi_cmd_pkg::rx_start;
            cycle_cnt <= '0;
            msg_done <= 1'b0;
            msg_valid <= 1'b0;
        end else begin
            msg_done <= 1'b0;
            msg_valid <= msg_done;

            case (state)
                spi_cmd_pkg::rx_start: begin
                    cycle_cnt <= spi_cmd_pkg::msg_cycle_count[spi_cmd_pkg::rx_cnt_width-1:0];
                    state <= spi_cmd_pkg::rx_shift;
                end

                spi_cmd_pkg::rx_shift: begin
                    if (cycle_cnt == '0) begin
                        state <= spi_cmd_pkg::rx_done;
                        msg_done <= 1'b1;
                    end else begin
                        cycle_cnt <= cycle_cnt - 1'b1;
                    end
                end

                spi_cmd_pkg::rx_done: begin
                    // One message per selection, wait for deselect
                end

                default: begin
                    state <= spi_cmd_pkg::rx_start;
                end
            endcase
        end
    end

    // ==============================
    // Message capture
    // ==============================

    // The host cannot send the top type bit set, so it is forced here
    always_ff @(posedge ice_st_spi_clk) begin
        if (msg_done) begin
            msg.msg_type <= {1'b1,
                shreg[spi_cmd_pkg::msg_len-2 -: spi_cmd_pkg::msg_type_len-1]};
            msg.arg <= shreg[spi_cmd_pkg::msg_arg_len-1:0];
        end
    end

endmodule

/* logic/spi_cmd_pkg.sv */
package spi_cmd_pkg;

    // ==============================
    // Message layout
    // ==============================

    localparam int msg_len = 64;
    localparam int msg_type_len = 8;
    localparam int msg_arg_len = 56;
    localparam int nibble_len = 4;

    // Start cycle and dummy byte ahead of the message nibbles
    localparam int msg_cycle_count = msg_len / nibble_len + 1;
    localparam int rx_cnt_width = $clog2(msg_cycle_count + 1);

    // Type bit that asks for a response
    localparam int msg_type_resp_bit = 6;

    // ==============================
    // Response layout
    // ==============================

    localparam int resp_len = 64;
    localparam int resp_word_len = 16;

    // Two nibbles leave per edge on the 8 data lines
    localparam int resp_beat_count = resp_len / (2 * nibble_len);

    // ==============================
    // Argument fields
    // ==============================

    localparam int led_width = 4;
    localparam int img_rst_bit = 0;

    typedef enum logic [msg_type_len-1:0] {
        op_nop       = 8'h80,
        op_led_set   = 8'h81,
        op_img_reset = 8'h82,
        op_echo      = 8'hC0
    } spi_opcode_t;

    typedef struct packed {
        logic [msg_type_len-1:0] msg_type;
        logic [msg_arg_len-1:0]  arg;
    } spi_msg_t;

    typedef enum logic [1:0] {
        rx_start,
        rx_shift,
        rx_done
    } rx_state_t;

    typedef enum logic {
        tx_idle,
        tx_send
    } tx_state_t;

endpackage
